// ==== hw/sd_spi_pkg.sv ====
package sd_spi_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [47:0] frame_t;
  typedef logic [47:0] rsp_t;
  typedef logic [7:0]  ctrl_t;  // [7] data read, [6:0] response bytes

  // Word addresses, matched against adr[31:2]
  localparam logic [29:0] REG_NOOP     = 30'd0;
  localparam logic [29:0] REG_CMD_SEND = 30'd1;
  localparam logic [29:0] REG_CMD_LO   = 30'd2;
  localparam logic [29:0] REG_CMD_HI   = 30'd3;
  localparam logic [29:0] REG_STATUS   = 30'd4;
  localparam logic [29:0] REG_RSP_LO   = 30'd5;
  localparam logic [29:0] REG_RSP_HI   = 30'd6;
  localparam logic [29:0] REG_DATA     = 30'd7;

  localparam int STAT_RSP  = 0;
  localparam int STAT_DATA = 1;
  localparam int STAT_BUSY = 2;

  localparam logic [7:0] START_TOKEN = 8'hFE;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQ,
    ST_SEND,
    ST_RSP_WAIT,
    ST_RSP,
    ST_TOKEN,
    ST_DATA,
    ST_CRC
  } eng_state_e;

endpackage

// ==== hw/sd_cmd_if.sv ====
`timescale 1ns/1ps

interface sd_cmd_if;

  sd_spi_pkg::frame_t frame;
  sd_spi_pkg::ctrl_t  ctrl;
  logic               start;  // One cycle

  sd_spi_pkg::rsp_t   rsp;
  logic               rsp_arrived;
  logic               data_arrived;
  logic               busy;
  logic               done;   // One cycle, end of transaction

  modport regs (
    output frame, ctrl, start,
    input  rsp, rsp_arrived, data_arrived, busy, done
  );

  modport engine (
    input  frame, ctrl, start,
    output rsp, rsp_arrived, data_arrived, busy, done
  );

endinterface

// ==== hw/sd_sck_gen.sv ====
`timescale 1ns/1ps

module sd_sck_gen #(
  parameter int SCK_DIV = 6
) (
  input  logic clk,
  input  logic rst,
  output logic sck_o,
  output logic tick_o
);

  localparam int CNT_W = $clog2(SCK_DIV + 2);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt    <= '0;
      sck_o  <= 1'b0;
      tick_o <= 1'b0;
    end
    else
    begin
      // High over the middle half of the period
      sck_o  <= (cnt >= CNT_W'(SCK_DIV / 4)) && (cnt <= CNT_W'(SCK_DIV * 3 / 4));
      tick_o <= (cnt >= CNT_W'(SCK_DIV));
      if (cnt >= CNT_W'(SCK_DIV))
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== hw/sd_bus_regs.sv ====
`timescale 1ns/1ps

module sd_bus_regs (
  input  logic              clk,
  input  logic              rst,
  input  logic              bus_cyc_i,
  input  logic              bus_stb_i,
  input  logic              bus_we_i,
  input  sd_spi_pkg::addr_t bus_adr_i,
  input  sd_spi_pkg::word_t bus_dat_i,
  output sd_spi_pkg::word_t bus_dat_o,
  output logic              bus_ack_o,
  sd_cmd_if.regs            cmd,
  output logic              word_rd_o,
  input  sd_spi_pkg::word_t word_i,
  input  logic              empty_i
);

  logic [29:0]        reg_sel;
  logic               access;
  logic               is_send;
  logic               ack_q;
  logic               send_pend;  // CMD_SEND waiting for done
  logic               start_q;
  sd_spi_pkg::frame_t frame_q;
  sd_spi_pkg::ctrl_t  ctrl_q;
  sd_spi_pkg::word_t  status;
  sd_spi_pkg::word_t  rdata_q;

  assign reg_sel = bus_adr_i[31:2];
  assign access  = bus_cyc_i && bus_stb_i && !ack_q;
  assign is_send = bus_we_i && (reg_sel == sd_spi_pkg::REG_CMD_SEND);

  // Pop in the accept cycle, word_i is latched on the same edge
  assign word_rd_o = access && !bus_we_i && (reg_sel == sd_spi_pkg::REG_DATA) && !empty_i;

  assign cmd.frame = frame_q;
  assign cmd.ctrl  = ctrl_q;
  assign cmd.start = start_q;

  assign bus_dat_o = rdata_q;
  assign bus_ack_o = ack_q || (send_pend && cmd.done);

  always_comb
  begin
    status = '0;
    status[sd_spi_pkg::STAT_RSP]  = cmd.rsp_arrived;
    status[sd_spi_pkg::STAT_DATA] = cmd.data_arrived;
    status[sd_spi_pkg::STAT_BUSY] = cmd.busy;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_q     <= 1'b0;
      send_pend <= 1'b0;
      start_q   <= 1'b0;
      frame_q   <= '0;
      ctrl_q    <= '0;
    end
    else
    begin
      ack_q   <= access && !is_send;
      start_q <= 1'b0;
      if (access && is_send && !send_pend && !cmd.busy)
      begin
        send_pend <= 1'b1;
        start_q   <= 1'b1;
      end
      else if (send_pend && cmd.done)
        send_pend <= 1'b0;

      if (access && bus_we_i)
      begin
        case (reg_sel)
          sd_spi_pkg::REG_CMD_LO: frame_q[31:0] <= bus_dat_i;
          sd_spi_pkg::REG_CMD_HI:
          begin
            frame_q[47:32] <= bus_dat_i[15:0];
            ctrl_q         <= bus_dat_i[31:24];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    rdata_q <= '0;
    if (access && !bus_we_i)
    begin
      case (reg_sel)
        sd_spi_pkg::REG_CMD_LO: rdata_q <= frame_q[31:0];
        sd_spi_pkg::REG_CMD_HI: rdata_q <= {ctrl_q, 8'h00, frame_q[47:32]};
        sd_spi_pkg::REG_STATUS: rdata_q <= status;
        sd_spi_pkg::REG_RSP_LO: rdata_q <= cmd.rsp[31:0];
        sd_spi_pkg::REG_RSP_HI: rdata_q <= {16'h0000, cmd.rsp[47:32]};
        sd_spi_pkg::REG_DATA:   rdata_q <= empty_i ? '0 : word_i;
        default:                rdata_q <= '0;  // NOOP and unmapped
      endcase
    end
  end

endmodule

// ==== hw/sd_spi_engine.sv ====
`timescale 1ns/1ps

module sd_spi_engine #(
  parameter int BLOCK_BYTES   = 512,
  parameter int TOKEN_TIMEOUT = 511
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     tick_i,
  sd_cmd_if.engine cmd,
  output logic     spi_req_o,
  input  logic     spi_ack_i,
  output logic     spi_done_o,
  output logic     cs_o,
  output logic     mosi_o,
  input  logic     miso_i,
  output logic     fifo_clr_o,
  output logic     bit_wr_o,
  output logic     bit_val_o
);

  localparam int DATA_BITS = BLOCK_BYTES * 8;
  localparam int CNT_W     = $clog2(DATA_BITS + TOKEN_TIMEOUT + 1024);

  sd_spi_pkg::eng_state_e state;
  logic [CNT_W-1:0]       cnt;
  logic [CNT_W-1:0]       rsp_bits;
  logic [47:0]            tx_sr;
  logic [7:0]             window;
  logic [7:0]             window_nxt;
  sd_spi_pkg::ctrl_t      ctrl_q;
  sd_spi_pkg::rsp_t       rsp_q;
  logic                   rsp_arr_q;
  logic                   data_arr_q;
  logic                   busy_q;
  logic                   done_q;

  assign rsp_bits   = CNT_W'({ctrl_q[6:0], 3'b000});
  assign window_nxt = {window[6:0], miso_i};

  assign bit_wr_o  = tick_i && (state == sd_spi_pkg::ST_DATA);
  assign bit_val_o = miso_i;

  assign cmd.rsp          = rsp_q;
  assign cmd.rsp_arrived  = rsp_arr_q;
  assign cmd.data_arrived = data_arr_q;
  assign cmd.busy         = busy_q;
  assign cmd.done         = done_q;
  assign spi_done_o       = done_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= sd_spi_pkg::ST_IDLE;
      cnt        <= '0;
      ctrl_q     <= '0;
      rsp_q      <= '0;
      rsp_arr_q  <= 1'b0;
      data_arr_q <= 1'b0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      spi_req_o  <= 1'b0;
      cs_o       <= 1'b1;
      mosi_o     <= 1'b1;
      fifo_clr_o <= 1'b0;
    end
    else
    begin
      done_q     <= 1'b0;
      fifo_clr_o <= 1'b0;
      case (state)
        sd_spi_pkg::ST_IDLE:
          if (cmd.start)
          begin
            ctrl_q     <= cmd.ctrl;
            rsp_q      <= '0;
            rsp_arr_q  <= 1'b0;
            data_arr_q <= 1'b0;
            busy_q     <= 1'b1;
            spi_req_o  <= 1'b1;
            state      <= sd_spi_pkg::ST_REQ;
          end
        sd_spi_pkg::ST_REQ:
          if (spi_ack_i)
          begin
            spi_req_o <= 1'b0;
            cnt       <= '0;
            state     <= sd_spi_pkg::ST_SEND;
          end
        sd_spi_pkg::ST_SEND:
          if (tick_i)
          begin
            cs_o <= 1'b0;
            if (cnt == CNT_W'(48))
            begin
              mosi_o <= 1'b1;
              state  <= sd_spi_pkg::ST_RSP_WAIT;
            end
            else
            begin
              mosi_o <= tx_sr[47];
              cnt    <= cnt + 1'b1;
            end
          end
        sd_spi_pkg::ST_RSP_WAIT:
          if (tick_i && !miso_i)  // Start bit
          begin
            rsp_q <= {rsp_q[46:0], miso_i};
            cnt   <= CNT_W'(1);
            state <= sd_spi_pkg::ST_RSP;
          end
        sd_spi_pkg::ST_RSP:
          if (tick_i)
          begin
            rsp_q <= {rsp_q[46:0], miso_i};
            cnt   <= cnt + 1'b1;
            if (cnt + 1'b1 >= rsp_bits)
            begin
              rsp_arr_q <= 1'b1;
              if (ctrl_q[7])
              begin
                fifo_clr_o <= 1'b1;
                cnt        <= '0;
                state      <= sd_spi_pkg::ST_TOKEN;
              end
              else
              begin
                cs_o   <= 1'b1;
                done_q <= 1'b1;
                busy_q <= 1'b0;
                state  <= sd_spi_pkg::ST_IDLE;
              end
            end
          end
        sd_spi_pkg::ST_TOKEN:
          if (tick_i)
          begin
            cnt <= cnt + 1'b1;
            if (window_nxt == sd_spi_pkg::START_TOKEN)
            begin
              cnt   <= '0;
              state <= sd_spi_pkg::ST_DATA;
            end
            else if (cnt == CNT_W'(TOKEN_TIMEOUT - 1))
            begin
              cs_o   <= 1'b1;
              done_q <= 1'b1;
              busy_q <= 1'b0;
              state  <= sd_spi_pkg::ST_IDLE;
            end
          end
        sd_spi_pkg::ST_DATA:
          if (tick_i)
          begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(DATA_BITS - 1))
            begin
              cnt   <= '0;
              state <= sd_spi_pkg::ST_CRC;
            end
          end
        sd_spi_pkg::ST_CRC:
          if (tick_i)
          begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(15))  // CRC16 dropped
            begin
              data_arr_q <= 1'b1;
              cs_o       <= 1'b1;
              done_q     <= 1'b1;
              busy_q     <= 1'b0;
              state      <= sd_spi_pkg::ST_IDLE;
            end
          end
        default: state <= sd_spi_pkg::ST_IDLE;
      endcase
    end
  end

  // Frame copy and token window
  always_ff @(posedge clk)
  begin
    if (state == sd_spi_pkg::ST_IDLE && cmd.start)
      tx_sr <= cmd.frame;
    else if (state == sd_spi_pkg::ST_SEND && tick_i)
      tx_sr <= {tx_sr[46:0], 1'b1};

    if (state != sd_spi_pkg::ST_TOKEN)
      window <= 8'hFF;
    else if (tick_i)
      window <= window_nxt;
  end

endmodule

// ==== hw/sd_block_fifo.sv ====
`timescale 1ns/1ps

module sd_block_fifo #(
  parameter int BLOCK_BYTES = 512
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              clr_i,
  input  logic              bit_wr_i,
  input  logic              bit_i,
  input  logic              rd_i,
  output sd_spi_pkg::word_t word_o,
  output logic              empty_o
);

  localparam int DEPTH = BLOCK_BYTES / 4;
  localparam int AW    = $clog2(DEPTH);

  sd_spi_pkg::word_t mem [DEPTH];
  sd_spi_pkg::word_t sr;
  logic [4:0]        bit_cnt;
  logic [AW:0]       wr_ptr;
  logic [AW:0]       rd_ptr;

  assign word_o  = mem[rd_ptr[AW-1:0]];
  assign empty_o = (wr_ptr == rd_ptr);

  always_ff @(posedge clk)
  begin
    if (rst || clr_i)
    begin
      bit_cnt <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
    end
    else
    begin
      if (bit_wr_i)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 5'd31)
          wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_i && !empty_o)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // MSB first, so the first byte lands in [31:24]
  always_ff @(posedge clk)
  begin
    if (bit_wr_i)
    begin
      sr <= {sr[30:0], bit_i};
      if (bit_cnt == 5'd31)
        mem[wr_ptr[AW-1:0]] <= {sr[30:0], bit_i};
    end
  end

endmodule

// ==== hw/sd_spi_top.sv ====
`timescale 1ns/1ps

module sd_spi_top #(
  parameter int SCK_DIV       = 6,
  parameter int BLOCK_BYTES   = 512,
  parameter int TOKEN_TIMEOUT = 511
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              bus_cyc_i,
  input  logic              bus_stb_i,
  input  logic              bus_we_i,
  input  sd_spi_pkg::addr_t bus_adr_i,
  input  sd_spi_pkg::word_t bus_dat_i,
  output sd_spi_pkg::word_t bus_dat_o,
  output logic              bus_ack_o,
  output logic              spi_req_o,
  input  logic              spi_ack_i,
  output logic              spi_done_o,
  output logic              sck_o,
  output logic              cs_o,
  output logic              mosi_o,
  input  logic              miso_i
);

  logic              tick;
  logic              fifo_clr;
  logic              bit_wr;
  logic              bit_val;
  logic              word_rd;
  sd_spi_pkg::word_t fifo_word;
  logic              fifo_empty;

  sd_cmd_if u_cmd ();

  sd_sck_gen #(
    .SCK_DIV (SCK_DIV)
  ) u_sck_gen (
    .clk    (clk),
    .rst    (rst),
    .sck_o  (sck_o),
    .tick_o (tick)
  );

  sd_bus_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .bus_cyc_i (bus_cyc_i),
    .bus_stb_i (bus_stb_i),
    .bus_we_i  (bus_we_i),
    .bus_adr_i (bus_adr_i),
    .bus_dat_i (bus_dat_i),
    .bus_dat_o (bus_dat_o),
    .bus_ack_o (bus_ack_o),
    .cmd       (u_cmd.regs),
    .word_rd_o (word_rd),
    .word_i    (fifo_word),
    .empty_i   (fifo_empty)
  );

  sd_spi_engine #(
    .BLOCK_BYTES   (BLOCK_BYTES),
    .TOKEN_TIMEOUT (TOKEN_TIMEOUT)
  ) u_engine (
    .clk        (clk),
    .rst        (rst),
    .tick_i     (tick),
    .cmd        (u_cmd.engine),
    .spi_req_o  (spi_req_o),
    .spi_ack_i  (spi_ack_i),
    .spi_done_o (spi_done_o),
    .cs_o       (cs_o),
    .mosi_o     (mosi_o),
    .miso_i     (miso_i),
    .fifo_clr_o (fifo_clr),
    .bit_wr_o   (bit_wr),
    .bit_val_o  (bit_val)
  );

  sd_block_fifo #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .clr_i    (fifo_clr),
    .bit_wr_i (bit_wr),
    .bit_i    (bit_val),
    .rd_i     (word_rd),
    .word_o   (fifo_word),
    .empty_o  (fifo_empty)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== bench/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model #(
  parameter int BLOCK_BYTES = 512
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cs_i,
  input  logic        sck_i,
  input  logic        mosi_i,
  input  logic        spi_req_i,
  input  logic [47:0] rsp_i,      // Response bytes, right-aligned
  input  logic [6:0]  rsp_len_i,
  input  logic        token_i,
  input  logic [31:0] seed_i,
  output logic        miso_o,
  output logic        spi_ack_o,
  output logic [47:0] frame_o,
  output int          frame_cnt_o
);

  logic        cs_q;
  logic        sck_q;
  logic [47:0] rx_sr;
  int          rx_cnt;
  logic [2:0]  req_wait;
  bit          stream[$];  // Bits still to send on MISO

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic push_byte(input logic [7:0] b);
    int i;
    for (i = 7; i >= 0; i--)
      stream.push_back(b[i]);
  endtask

  task automatic build_stream();
    logic [31:0] s;
    int          i;
    stream.delete();
    push_byte(8'hFF);  // Gap before the response
    for (i = int'(rsp_len_i) - 1; i >= 0; i--)
      push_byte(rsp_i[i*8 +: 8]);
    if (token_i)
    begin
      push_byte(8'hFF);
      push_byte(8'hFF);
      push_byte(8'hFE);
      s = seed_i;
      for (i = 0; i < BLOCK_BYTES; i++)
      begin
        s = lcg_step(s);
        push_byte(s[23:16]);
      end
      push_byte(8'h3C);  // CRC, never checked by the controller
      push_byte(8'hC3);
    end
  endtask

  initial
  begin
    miso_o    = 1'b1;
    spi_ack_o = 1'b0;
  end

  // Pins are sampled and driven on the falling clk edge
  always @(negedge clk)
  begin
    if (rst)
    begin
      cs_q        <= 1'b1;
      sck_q       <= 1'b0;
      miso_o      <= 1'b1;
      rx_cnt      <= 0;
      frame_o     <= '0;
      frame_cnt_o <= 0;
    end
    else
    begin
      cs_q  <= cs_i;
      sck_q <= sck_i;
      if (!cs_i && cs_q)
      begin
        build_stream();
        rx_cnt <= 0;
      end
      else if (!cs_i && sck_i && !sck_q)
      begin
        if (rx_cnt < 48)
        begin
          rx_sr  <= {rx_sr[46:0], mosi_i};
          rx_cnt <= rx_cnt + 1;
        end
        else if (stream.size() > 0)
          miso_o <= stream.pop_front();
        else
          miso_o <= 1'b1;
      end
      if (cs_i && !cs_q)
      begin
        frame_o     <= rx_sr;
        frame_cnt_o <= frame_cnt_o + 1;
        miso_o      <= 1'b1;
      end
    end
  end

  // Arbiter grant a few cycles after the request
  always @(negedge clk)
  begin
    if (rst)
    begin
      spi_ack_o <= 1'b0;
      req_wait  <= '0;
    end
    else if (spi_ack_o)
      spi_ack_o <= 1'b0;
    else if (spi_req_i)
    begin
      if (req_wait == 3'd3)
      begin
        spi_ack_o <= 1'b1;
        req_wait  <= '0;
      end
      else
        req_wait <= req_wait + 1'b1;
    end
  end

endmodule

// ==== bench/sd_spi_assertions.sv ====
`timescale 1ns/1ps

module sd_spi_assertions (
  input logic clk,
  input logic rst,
  input logic tick,
  input logic cs_o,
  input logic mosi_o,
  input logic spi_req_o,
  input logic spi_ack_i,
  input logic spi_done_o,
  input logic bus_ack_o
);

  int fail_cnt = 0;

  a_bus_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    bus_ack_o |=> !bus_ack_o)
    else
    begin
      fail_cnt++;
      $error("bus_ack_o high for more than one cycle");
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    spi_done_o |=> !spi_done_o)
    else
    begin
      fail_cnt++;
      $error("spi_done_o high for more than one cycle");
    end

  // Pins move only on a shift tick
  a_mosi_on_tick: assert property (@(posedge clk) disable iff (rst)
    (mosi_o != $past(mosi_o)) |-> $past(tick))
    else
    begin
      fail_cnt++;
      $error("mosi_o changed outside a tick");
    end

  a_cs_on_tick: assert property (@(posedge clk) disable iff (rst)
    (cs_o != $past(cs_o)) |-> $past(tick))
    else
    begin
      fail_cnt++;
      $error("cs_o changed outside a tick");
    end

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    (spi_req_o && !spi_ack_i) |=> spi_req_o)
    else
    begin
      fail_cnt++;
      $error("spi_req_o dropped before the grant");
    end

endmodule

bind sd_spi_top sd_spi_assertions u_assert (
  .clk        (clk),
  .rst        (rst),
  .tick       (tick),
  .cs_o       (cs_o),
  .mosi_o     (mosi_o),
  .spi_req_o  (spi_req_o),
  .spi_ack_i  (spi_ack_i),
  .spi_done_o (spi_done_o),
  .bus_ack_o  (bus_ack_o)
);

// ==== bench/tb_sd_spi.sv ====
`timescale 1ns/1ps

module tb_sd_spi;

  localparam int SCK_DIV       = 6;
  localparam int BLOCK_BYTES   = 512;
  localparam int TOKEN_TIMEOUT = 511;
  localparam int BLOCK_WORDS   = BLOCK_BYTES / 4;
  localparam int LINE_CYCLES   = (BLOCK_BYTES * 8 + TOKEN_TIMEOUT + 256) * (SCK_DIV + 1) + 2000;

  logic        clk;
  logic        rst;
  logic        bus_cyc;
  logic        bus_stb;
  logic        bus_we;
  logic [31:0] bus_adr;
  logic [31:0] bus_dat_w;
  logic [31:0] bus_dat_r;
  logic        bus_ack;
  logic        spi_req;
  logic        spi_ack;
  logic        spi_done;
  logic        sck;
  logic        cs;
  logic        mosi;
  logic        miso;

  logic [47:0] card_rsp;
  logic [6:0]  card_rsp_len;
  logic        card_token;
  logic [31:0] card_seed;
  logic [47:0] card_frame;
  int          card_frames;

  // One entry per trace line
  logic [47:0] tr_frame[$];
  logic [7:0]  tr_ctrl[$];
  logic [47:0] tr_rsp[$];
  logic        tr_token[$];
  logic [31:0] tr_seed[$];
  logic [47:0] tr_exp_frame[$];
  logic [31:0] tr_status[$];

  int errors      = 0;
  int done_cnt    = 0;
  int cycles      = 0;
  int cycle_limit = LINE_CYCLES;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  sd_spi_top #(
    .SCK_DIV       (SCK_DIV),
    .BLOCK_BYTES   (BLOCK_BYTES),
    .TOKEN_TIMEOUT (TOKEN_TIMEOUT)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .bus_cyc_i  (bus_cyc),
    .bus_stb_i  (bus_stb),
    .bus_we_i   (bus_we),
    .bus_adr_i  (bus_adr),
    .bus_dat_i  (bus_dat_w),
    .bus_dat_o  (bus_dat_r),
    .bus_ack_o  (bus_ack),
    .spi_req_o  (spi_req),
    .spi_ack_i  (spi_ack),
    .spi_done_o (spi_done),
    .sck_o      (sck),
    .cs_o       (cs),
    .mosi_o     (mosi),
    .miso_i     (miso)
  );

  sd_card_model #(
    .BLOCK_BYTES (BLOCK_BYTES)
  ) u_card (
    .clk         (clk),
    .rst         (rst),
    .cs_i        (cs),
    .sck_i       (sck),
    .mosi_i      (mosi),
    .spi_req_i   (spi_req),
    .rsp_i       (card_rsp),
    .rsp_len_i   (card_rsp_len),
    .token_i     (card_token),
    .seed_i      (card_seed),
    .miso_o      (miso),
    .spi_ack_o   (spi_ack),
    .frame_o     (card_frame),
    .frame_cnt_o (card_frames)
  );

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input logic [47:0] got, input logic [47:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic bus_write(input logic [29:0] sel, input logic [31:0] data);
    @(negedge clk);
    bus_cyc   = 1'b1;
    bus_stb   = 1'b1;
    bus_we    = 1'b1;
    bus_adr   = {sel, 2'b00};
    bus_dat_w = data;
    do
      @(negedge clk);
    while (!bus_ack);
    bus_cyc = 1'b0;
    bus_stb = 1'b0;
    bus_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [29:0] sel, output logic [31:0] data);
    @(negedge clk);
    bus_cyc = 1'b1;
    bus_stb = 1'b1;
    bus_we  = 1'b0;
    bus_adr = {sel, 2'b00};
    do
      @(negedge clk);
    while (!bus_ack);
    data    = bus_dat_r;
    bus_cyc = 1'b0;
    bus_stb = 1'b0;
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [47:0] f;
    logic [47:0] r;
    logic [47:0] ef;
    logic [7:0]  c;
    logic        t;
    logic [31:0] sd;
    logic [31:0] st;
    fd = $fopen("bench/sd_trace.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the trace file bench/sd_trace.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", f, c, r, t, sd, ef, st);
        if (n == 7)
        begin
          tr_frame.push_back(f);
          tr_ctrl.push_back(c);
          tr_rsp.push_back(r);
          tr_token.push_back(t);
          tr_seed.push_back(sd);
          tr_exp_frame.push_back(ef);
          tr_status.push_back(st);
        end
      end
    end
    $fclose(fd);
    cycle_limit = (tr_frame.size() + 1) * LINE_CYCLES;
  endtask

  task automatic check_idle_regs();
    logic [31:0] rd;
    check_val("cs_o", cs, 1);
    check_val("mosi_o", mosi, 1);
    check_val("spi_req_o", spi_req, 0);
    check_val("sck_o", sck, 0);
    bus_read(sd_spi_pkg::REG_STATUS, rd);
    check_val("STATUS", rd, 0);
    bus_write(sd_spi_pkg::REG_CMD_LO, 32'h1234_5678);
    bus_write(sd_spi_pkg::REG_CMD_HI, 32'hA511_BEEF);
    bus_read(sd_spi_pkg::REG_CMD_LO, rd);
    check_val("CMD_LO", rd, 32'h1234_5678);
    bus_read(sd_spi_pkg::REG_CMD_HI, rd);
    check_val("CMD_HI", rd, 32'hA500_BEEF);  // Middle byte is not stored
    bus_read(sd_spi_pkg::REG_NOOP, rd);
    check_val("NOOP", rd, 0);
    bus_read(30'h10, rd);
    check_val("unmapped read", rd, 0);
  endtask

  task automatic run_line(input int idx);
    logic [47:0] frame;
    logic [7:0]  ctrl;
    logic [47:0] rsp_exp;
    logic [31:0] rd;
    logic [31:0] s;
    logic [31:0] exp_word;
    int          done_before;
    int          frames_before;
    int          w;
    int          b;
    frame   = tr_frame[idx];
    ctrl    = tr_ctrl[idx];
    rsp_exp = tr_rsp[idx] & ((48'h1 << (ctrl[6:0] * 8)) - 48'h1);
    card_rsp     = tr_rsp[idx];
    card_rsp_len = ctrl[6:0];
    card_token   = tr_token[idx];
    card_seed    = tr_seed[idx];
    bus_write(sd_spi_pkg::REG_CMD_LO, frame[31:0]);
    bus_write(sd_spi_pkg::REG_CMD_HI, {ctrl, 8'h00, frame[47:32]});
    done_before   = done_cnt;
    frames_before = card_frames;
    bus_write(sd_spi_pkg::REG_CMD_SEND, 32'h0);
    if (cs !== 1'b1)
    begin
      errors++;
      $display("Line %0d: CMD_SEND was acked while cs_o was still low", idx);
    end
    bus_read(sd_spi_pkg::REG_STATUS, rd);
    check_val("STATUS", rd, tr_status[idx]);
    bus_read(sd_spi_pkg::REG_RSP_LO, rd);
    check_val("RSP_LO", rd, rsp_exp[31:0]);
    bus_read(sd_spi_pkg::REG_RSP_HI, rd);
    check_val("RSP_HI", rd, {16'h0, rsp_exp[47:32]});
    check_val("card frame", card_frame, tr_exp_frame[idx]);
    check_val("card frame count", card_frames, frames_before + 1);
    check_val("spi_done_o pulses", done_cnt, done_before + 1);
    if (tr_status[idx][sd_spi_pkg::STAT_DATA])
    begin
      s = tr_seed[idx];
      for (w = 0; w < BLOCK_WORDS; w++)
      begin
        exp_word = '0;
        for (b = 0; b < 4; b++)
        begin
          s        = next_rand(s);
          exp_word = {exp_word[23:0], s[23:16]};
        end
        bus_read(sd_spi_pkg::REG_DATA, rd);
        check_val($sformatf("DATA[%0d]", w), rd, exp_word);
      end
      bus_read(sd_spi_pkg::REG_DATA, rd);
      check_val("DATA after block", rd, 0);
    end
    else if (ctrl[7])
    begin
      bus_read(sd_spi_pkg::REG_DATA, rd);
      check_val("DATA without token", rd, 0);
      bus_read(sd_spi_pkg::REG_DATA, rd);
      check_val("DATA without token", rd, 0);
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst && spi_done)
      done_cnt++;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, a transaction never completed", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial
  begin
    int i;
    int afail;
    bus_cyc      = 1'b0;
    bus_stb      = 1'b0;
    bus_we       = 1'b0;
    bus_adr      = '0;
    bus_dat_w    = '0;
    card_rsp     = '0;
    card_rsp_len = 7'd1;
    card_token   = 1'b0;
    card_seed    = 32'hdc01_f123;
    load_trace();
    @(negedge clk);
    while (rst)
      @(negedge clk);
    check_idle_regs();
    for (i = 0; i < tr_frame.size(); i++)
      run_line(i);
    repeat (4) @(negedge clk);
    afail = u_dut.u_assert.fail_cnt;
    $display("Summary: %0d check errors, %0d assertion failures", errors, afail);
    if (errors == 0 && afail == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== bench/sd_trace.txt ====
# frame ctrl response token seed expected_frame expected_status
# response is right-aligned, ctrl[6:0] bytes long, token 1 means a data block follows
400000000095 01 000000000001 0 dc01f123 400000000095 1
48000001aa87 05 0001000001aa 0 dc01f123 48000001aa87 1
510000000055 81 000000000000 1 dc01f123 510000000055 3
5100000200ff 81 000000000000 0 00000000 5100000200ff 1
7a00000000fd 05 0000c0ff8000 0 00000000 7a00000000fd 1
510000040033 81 000000000000 1 1234abcd 510000040033 3

// ==== src.f ====
hw/sd_spi_pkg.sv
hw/sd_cmd_if.sv
hw/sd_sck_gen.sv
hw/sd_bus_regs.sv
hw/sd_spi_engine.sv
hw/sd_block_fifo.sv
hw/sd_spi_top.sv
bench/tb_clk_gen.sv
bench/sd_card_model.sv
bench/sd_spi_assertions.sv
bench/tb_sd_spi.sv

// ==== Makefile ====
TOP = tb_sd_spi

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, log in sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim
	./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "ERRORS FOUND" sim.log || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
